/* source/rr_pkg.sv */
`default_nettype none

//////////////////////////////
// Shared widths and encodings
//////////////////////////////

package rr_pkg;

  // Write channel widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Configuration port offset width
  localparam int CFG_ADDR_W = 2;

  // Operating mode of the shim
  // Encoding 2'b11 is unused
  typedef enum logic [1:0] {
    RR_PASS   = 2'd0,
    RR_RECORD = 2'd1,
    RR_REPLAY = 2'd2
  } rr_mode_e;

  // Configuration register offsets
  // CFG_MODE takes the new mode from the low two data bits
  // CFG_CLEAR empties the trace
  // CFG_REPLAY_START kicks off a replay, honored only in replay mode
  typedef enum logic [CFG_ADDR_W-1:0] {
    CFG_MODE         = 2'd0,
    CFG_CLEAR        = 2'd1,
    CFG_REPLAY_START = 2'd2
  } cfg_reg_e;

  // Replayer FSM states
  // Fetch waits one cycle for the trace read
  // Issue holds the write until the user logic takes it
  typedef enum logic [1:0] {
    RP_IDLE  = 2'd0,
    RP_FETCH = 2'd1,
    RP_ISSUE = 2'd2
  } replay_state_e;

endpackage

`default_nettype wire

/* source/rr_csrs.sv */
`default_nettype none

module rr_csrs #(
  parameter int MODE_STAGES = 4
) (
  input  wire                       clk,
  input  wire                       i_reset,
  input  wire                       i_cfg_wr,
  input  var rr_pkg::cfg_reg_e      i_cfg_addr,
  input  wire [rr_pkg::DATA_W-1:0]  i_cfg_wdata,
  output rr_pkg::rr_mode_e          o_mode,
  output logic                      o_clear,
  output logic                      o_replay_start
);

  //////////////////////////////
  // Register stage
  //////////////////////////////

  rr_pkg::rr_mode_e       mode_r;
  logic                   clear_r;
  logic                   start_r;
  rr_pkg::rr_mode_e       wdata_mode;
  rr_pkg::rr_mode_e       mode_pipe [MODE_STAGES];
  logic [MODE_STAGES-1:0] clear_pipe;
  logic [MODE_STAGES-1:0] start_pipe;

  // Requested mode as carried in the write data
  assign wdata_mode = rr_pkg::rr_mode_e'(i_cfg_wdata[1:0]);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      mode_r  <= rr_pkg::RR_PASS;
      clear_r <= 1'b0;
      start_r <= 1'b0;
    end else begin
      // Command strobes last a single cycle
      clear_r <= i_cfg_wr && (i_cfg_addr == rr_pkg::CFG_CLEAR);
      // Start only counts once replay mode is already registered
      start_r <= i_cfg_wr && (i_cfg_addr == rr_pkg::CFG_REPLAY_START) &&
                 (mode_r == rr_pkg::RR_REPLAY);
      // Low two data bits give the new mode
      if (i_cfg_wr && (i_cfg_addr == rr_pkg::CFG_MODE)) begin
        mode_r <= wdata_mode;
      end
    end
  end

  //////////////////////////////
  // Mode and command pipeline
  //////////////////////////////

  // Mode and pulses move together so every channel switches in one cycle
  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < MODE_STAGES; i++) begin
        mode_pipe[i] <= rr_pkg::RR_PASS;
      end
      clear_pipe <= '0;
      start_pipe <= '0;
    end else begin
      mode_pipe[0]  <= mode_r;
      clear_pipe[0] <= clear_r;
      start_pipe[0] <= start_r;
      for (int i = 1; i < MODE_STAGES; i++) begin
        mode_pipe[i]  <= mode_pipe[i-1];
        clear_pipe[i] <= clear_pipe[i-1];
        start_pipe[i] <= start_pipe[i-1];
      end
    end
  end

  // Last stage feeds the consumers
  assign o_mode         = mode_pipe[MODE_STAGES-1];
  assign o_clear        = clear_pipe[MODE_STAGES-1];
  assign o_replay_start = start_pipe[MODE_STAGES-1];

  // Mode seen by the channels never carries the unused encoding
  a_mode_legal: assert property (@(posedge clk) disable iff (i_reset)
    o_mode inside {rr_pkg::RR_PASS, rr_pkg::RR_RECORD, rr_pkg::RR_REPLAY});

endmodule

`default_nettype wire

/* source/rr_write_recorder.sv */
`default_nettype none

module rr_write_recorder (
  input  wire                        clk,
  input  wire                        i_reset,
  input  var rr_pkg::rr_mode_e       i_mode,
  // Host side
  input  wire                        i_host_wvalid,
  output logic                       o_host_wready,
  input  wire [rr_pkg::ADDR_W-1:0]   i_host_waddr,
  input  wire [rr_pkg::DATA_W-1:0]   i_host_wdata,
  // Replay side
  input  wire                        i_rp_wvalid,
  output logic                       o_rp_wready,
  input  wire [rr_pkg::ADDR_W-1:0]   i_rp_waddr,
  input  wire [rr_pkg::DATA_W-1:0]   i_rp_wdata,
  // User logic side
  output logic                       o_cl_wvalid,
  input  wire                        i_cl_wready,
  output logic [rr_pkg::ADDR_W-1:0]  o_cl_waddr,
  output logic [rr_pkg::DATA_W-1:0]  o_cl_wdata,
  // Log entries toward the trace
  output logic                       o_log_valid,
  output logic [rr_pkg::ADDR_W-1:0]  o_log_addr,
  output logic [rr_pkg::DATA_W-1:0]  o_log_data
);

  //////////////////////////////
  // Source select
  //////////////////////////////

  logic replay_sel;
  logic record_en;
  logic xfer;

  assign replay_sel = (i_mode == rr_pkg::RR_REPLAY);
  assign record_en  = (i_mode == rr_pkg::RR_RECORD);

  // Combinational path from the chosen source to the user logic
  assign o_cl_wvalid = replay_sel ? i_rp_wvalid : i_host_wvalid;
  assign o_cl_waddr  = replay_sel ? i_rp_waddr  : i_host_waddr;
  assign o_cl_wdata  = replay_sel ? i_rp_wdata  : i_host_wdata;

  // Ready only reaches the side that is selected
  // Host stalls for the whole replay
  assign o_host_wready = !replay_sel && i_cl_wready;
  assign o_rp_wready   = replay_sel && i_cl_wready;

  // Completed transfer at the user logic port
  assign xfer = o_cl_wvalid && i_cl_wready;

  //////////////////////////////
  // Log entry
  //////////////////////////////

  // Strobe lands one cycle after the accepted write
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_log_valid <= 1'b0;
    end else begin
      o_log_valid <= record_en && xfer;
    end
  end

  // Payload only loads on a transfer
  always_ff @(posedge clk) begin
    if (xfer) begin
      o_log_addr <= o_cl_waddr;
      o_log_data <= o_cl_wdata;
    end
  end

  // A stalled write keeps its address until taken, unless the mode flips
  a_cl_addr_hold: assert property (@(posedge clk) disable iff (i_reset)
    (o_cl_wvalid && !i_cl_wready) ##1 $stable(i_mode)
      |-> o_cl_wvalid && $stable(o_cl_waddr));

endmodule

`default_nettype wire

/* source/rr_trace_buffer.sv */
`default_nettype none

module rr_trace_buffer #(
  parameter int TRACE_DEPTH = 16
) (
  input  wire                               clk,
  input  wire                               i_reset,
  input  wire                               i_clear,
  // Append side
  input  wire                               i_log_valid,
  input  wire [rr_pkg::ADDR_W-1:0]          i_log_addr,
  input  wire [rr_pkg::DATA_W-1:0]          i_log_data,
  // Indexed read side
  input  wire [$clog2(TRACE_DEPTH)-1:0]     i_rd_index,
  output logic [rr_pkg::ADDR_W-1:0]         o_rd_addr,
  output logic [rr_pkg::DATA_W-1:0]         o_rd_data,
  // Status
  output logic [$clog2(TRACE_DEPTH+1)-1:0]  o_count,
  output logic                              o_overflow
);

  localparam int IDX_W = $clog2(TRACE_DEPTH);
  localparam int CNT_W = $clog2(TRACE_DEPTH+1);

  //////////////////////////////
  // Storage
  //////////////////////////////

  logic [rr_pkg::ADDR_W-1:0] mem_addr [TRACE_DEPTH];
  logic [rr_pkg::DATA_W-1:0] mem_data [TRACE_DEPTH];
  logic [CNT_W-1:0]          count_q;
  logic                      overflow_q;
  logic                      full;
  logic                      append;

  assign full = (count_q == CNT_W'(TRACE_DEPTH));

  // Clear wins over a same-cycle entry
  assign append = i_log_valid && !full && !i_clear;

  // Entries go in at the current count
  always_ff @(posedge clk) begin
    if (append) begin
      mem_addr[count_q[IDX_W-1:0]] <= i_log_addr;
      mem_data[count_q[IDX_W-1:0]] <= i_log_data;
    end
  end

  //////////////////////////////
  // Count and overflow
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else if (append) begin
      count_q <= count_q + 1'b1;
    end else if (i_log_valid && full) begin
      // Entry dropped, flag stays up until a clear
      overflow_q <= 1'b1;
    end
  end

  assign o_count    = count_q;
  assign o_overflow = overflow_q;

  //////////////////////////////
  // Registered read
  //////////////////////////////

  // Reads leave the trace intact so it can replay again
  always_ff @(posedge clk) begin
    o_rd_addr <= mem_addr[i_rd_index];
    o_rd_data <= mem_data[i_rd_index];
  end

endmodule

`default_nettype wire

/* source/rr_write_replayer.sv */
`default_nettype none

module rr_write_replayer #(
  parameter int TRACE_DEPTH = 16
) (
  input  wire                               clk,
  input  wire                               i_reset,
  input  wire                               i_start,
  input  wire [$clog2(TRACE_DEPTH+1)-1:0]   i_count,
  // Trace read port
  output logic [$clog2(TRACE_DEPTH)-1:0]    o_rd_index,
  input  wire [rr_pkg::ADDR_W-1:0]          i_rd_addr,
  input  wire [rr_pkg::DATA_W-1:0]          i_rd_data,
  // Replay write channel
  output logic                              o_rp_wvalid,
  input  wire                               i_rp_wready,
  output logic [rr_pkg::ADDR_W-1:0]         o_rp_waddr,
  output logic [rr_pkg::DATA_W-1:0]         o_rp_wdata,
  output logic                              o_busy
);

  localparam int IDX_W = $clog2(TRACE_DEPTH);
  localparam int CNT_W = $clog2(TRACE_DEPTH+1);

  rr_pkg::replay_state_e state_q;
  logic [CNT_W-1:0]      count_q;
  logic [CNT_W-1:0]      idx_q;
  logic [CNT_W-1:0]      idx_next;

  assign idx_next   = idx_q + 1'b1;
  assign o_rd_index = idx_q[IDX_W-1:0];

  // Trace read data goes straight out while issuing
  assign o_rp_wvalid = (state_q == rr_pkg::RP_ISSUE);
  assign o_rp_waddr  = i_rd_addr;
  assign o_rp_wdata  = i_rd_data;
  assign o_busy      = (state_q != rr_pkg::RP_IDLE);

  //////////////////////////////
  // Replay FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= rr_pkg::RP_IDLE;
      count_q <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        rr_pkg::RP_IDLE: begin
          // Snapshot the trace length, start from entry zero
          if (i_start) begin
            count_q <= i_count;
            idx_q   <= '0;
            state_q <= rr_pkg::RP_FETCH;
          end
        end
        rr_pkg::RP_FETCH: begin
          // Empty trace ends here after one busy cycle
          state_q <= (idx_q == count_q) ? rr_pkg::RP_IDLE : rr_pkg::RP_ISSUE;
        end
        rr_pkg::RP_ISSUE: begin
          if (i_rp_wready) begin
            idx_q   <= idx_next;
            state_q <= (idx_next == count_q) ? rr_pkg::RP_IDLE : rr_pkg::RP_FETCH;
          end
        end
        default: state_q <= rr_pkg::RP_IDLE;
      endcase
    end
  end

  // Valid only while issuing, with the read index unchanged since the fetch
  a_issue_aligned: assert property (@(posedge clk) disable iff (i_reset)
    o_rp_wvalid |-> (state_q == rr_pkg::RP_ISSUE) &&
                    ($past(state_q) != rr_pkg::RP_IDLE) && $stable(o_rd_index));

endmodule

`default_nettype wire

/* source/rr_wrapper.sv */
`default_nettype none

module rr_wrapper #(
  parameter int TRACE_DEPTH = 16,
  parameter int MODE_STAGES = 4
) (
  input  wire                               clk,
  input  wire                               i_reset,
  // Configuration port
  input  wire                               i_cfg_wr,
  input  var rr_pkg::cfg_reg_e              i_cfg_addr,
  input  wire [rr_pkg::DATA_W-1:0]          i_cfg_wdata,
  // Host write channel
  input  wire                               i_host_wvalid,
  output logic                              o_host_wready,
  input  wire [rr_pkg::ADDR_W-1:0]          i_host_waddr,
  input  wire [rr_pkg::DATA_W-1:0]          i_host_wdata,
  // User logic write channel
  output logic                              o_cl_wvalid,
  input  wire                               i_cl_wready,
  output logic [rr_pkg::ADDR_W-1:0]         o_cl_waddr,
  output logic [rr_pkg::DATA_W-1:0]         o_cl_wdata,
  // Status
  output logic [$clog2(TRACE_DEPTH+1)-1:0]  o_trace_count,
  output logic                              o_trace_overflow,
  output logic                              o_replay_busy
);

  rr_pkg::rr_mode_e                   mode;
  logic                               clear;
  logic                               replay_start;
  logic                               log_valid;
  logic [rr_pkg::ADDR_W-1:0]          log_addr;
  logic [rr_pkg::DATA_W-1:0]          log_data;
  logic [$clog2(TRACE_DEPTH)-1:0]     rd_index;
  logic [rr_pkg::ADDR_W-1:0]          rd_addr;
  logic [rr_pkg::DATA_W-1:0]          rd_data;
  logic                               rp_wvalid;
  logic                               rp_wready;
  logic [rr_pkg::ADDR_W-1:0]          rp_waddr;
  logic [rr_pkg::DATA_W-1:0]          rp_wdata;

  //////////////////////////////
  // Mode and commands
  //////////////////////////////

  rr_csrs #(.MODE_STAGES(MODE_STAGES)) csrs_i (
    .clk(clk), .i_reset(i_reset),
    .i_cfg_wr(i_cfg_wr), .i_cfg_addr(i_cfg_addr), .i_cfg_wdata(i_cfg_wdata),
    .o_mode(mode), .o_clear(clear), .o_replay_start(replay_start)
  );

  // Host or replay toward the user logic, logging on the way
  rr_write_recorder recorder_i (
    .clk(clk), .i_reset(i_reset), .i_mode(mode),
    .i_host_wvalid(i_host_wvalid), .o_host_wready(o_host_wready),
    .i_host_waddr(i_host_waddr), .i_host_wdata(i_host_wdata),
    .i_rp_wvalid(rp_wvalid), .o_rp_wready(rp_wready),
    .i_rp_waddr(rp_waddr), .i_rp_wdata(rp_wdata),
    .o_cl_wvalid(o_cl_wvalid), .i_cl_wready(i_cl_wready),
    .o_cl_waddr(o_cl_waddr), .o_cl_wdata(o_cl_wdata),
    .o_log_valid(log_valid), .o_log_addr(log_addr), .o_log_data(log_data)
  );

  //////////////////////////////
  // Trace and playback
  //////////////////////////////

  rr_trace_buffer #(.TRACE_DEPTH(TRACE_DEPTH)) trace_i (
    .clk(clk), .i_reset(i_reset), .i_clear(clear),
    .i_log_valid(log_valid), .i_log_addr(log_addr), .i_log_data(log_data),
    .i_rd_index(rd_index), .o_rd_addr(rd_addr), .o_rd_data(rd_data),
    .o_count(o_trace_count), .o_overflow(o_trace_overflow)
  );

  rr_write_replayer #(.TRACE_DEPTH(TRACE_DEPTH)) replayer_i (
    .clk(clk), .i_reset(i_reset), .i_start(replay_start), .i_count(o_trace_count),
    .o_rd_index(rd_index), .i_rd_addr(rd_addr), .i_rd_data(rd_data),
    .o_rp_wvalid(rp_wvalid), .i_rp_wready(rp_wready),
    .o_rp_waddr(rp_waddr), .o_rp_wdata(rp_wdata),
    .o_busy(o_replay_busy)
  );

endmodule

`default_nettype wire

/* sim/tb_rr_wrapper.sv */
`default_nettype none

module tb_rr_wrapper;

  localparam int TRACE_DEPTH = 4;
  localparam int MODE_STAGES = 4;
  localparam int CNT_W       = $clog2(TRACE_DEPTH + 1);
  localparam int GOLDEN_MAX  = 128;

  // Golden command codes, top nibble of each word
  localparam logic [3:0] OP_END     = 4'd0;
  localparam logic [3:0] OP_CFG     = 4'd1;
  localparam logic [3:0] OP_HOST    = 4'd2;
  localparam logic [3:0] OP_EXPECT  = 4'd3;
  localparam logic [3:0] OP_WAIT    = 4'd4;
  localparam logic [3:0] OP_STATUS  = 4'd5;
  localparam logic [3:0] OP_BLOCKED = 4'd6;

  logic                      clk = 1'b0;
  logic                      i_reset = 1'b1;
  logic                      i_cfg_wr = 1'b0;
  rr_pkg::cfg_reg_e          i_cfg_addr = rr_pkg::CFG_MODE;
  logic [rr_pkg::DATA_W-1:0] i_cfg_wdata = '0;
  logic                      i_host_wvalid = 1'b0;
  logic                      o_host_wready;
  logic [rr_pkg::ADDR_W-1:0] i_host_waddr = '0;
  logic [rr_pkg::DATA_W-1:0] i_host_wdata = '0;
  logic                      o_cl_wvalid;
  logic                      i_cl_wready = 1'b0;
  logic [rr_pkg::ADDR_W-1:0] o_cl_waddr;
  logic [rr_pkg::DATA_W-1:0] o_cl_wdata;
  logic [CNT_W-1:0]          o_trace_count;
  logic                      o_trace_overflow;
  logic                      o_replay_busy;

  logic [63:0] golden [GOLDEN_MAX];
  logic [47:0] expected_q [$];
  logic [31:0] lfsr = 32'h0702_3d61;
  int          err_value = 0;
  int          err_other = 0;
  int          cmd_count = 0;
  int          cycle_limit = 0;
  int          cycle_count = 0;

  rr_wrapper #(.TRACE_DEPTH(TRACE_DEPTH), .MODE_STAGES(MODE_STAGES)) rr_wrapper_i (
    .clk(clk), .i_reset(i_reset),
    .i_cfg_wr(i_cfg_wr), .i_cfg_addr(i_cfg_addr), .i_cfg_wdata(i_cfg_wdata),
    .i_host_wvalid(i_host_wvalid), .o_host_wready(o_host_wready),
    .i_host_waddr(i_host_waddr), .i_host_wdata(i_host_wdata),
    .o_cl_wvalid(o_cl_wvalid), .i_cl_wready(i_cl_wready),
    .o_cl_waddr(o_cl_waddr), .o_cl_wdata(o_cl_wdata),
    .o_trace_count(o_trace_count), .o_trace_overflow(o_trace_overflow),
    .o_replay_busy(o_replay_busy)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // User logic ready
  //////////////////////////////

  // Right-shift Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One step per bit, about half the cycles ready
  always @(negedge clk) begin
    lfsr = lfsr_next(lfsr);
    i_cl_wready = lfsr[0];
  end

  //////////////////////////////
  // Monitor and watchdog
  //////////////////////////////

  // Every transfer at the user logic port must match the queue head
  always @(posedge clk) begin
    logic [47:0] head;
    if (!i_reset && o_cl_wvalid && i_cl_wready) begin
      if (expected_q.size() == 0) begin
        err_other++;
        $display("Unexpected write at the user logic port at t=%0t, addr %h data %h",
                 $time, o_cl_waddr, o_cl_wdata);
      end else begin
        head = expected_q.pop_front();
        if (o_cl_waddr !== head[47:32]) begin
          err_value++;
          $display("ERR t=%0t o_cl_waddr expected %h got %h", $time, head[47:32], o_cl_waddr);
        end
        if (o_cl_wdata !== head[31:0]) begin
          err_value++;
          $display("ERR t=%0t o_cl_wdata expected %h got %h", $time, head[31:0], o_cl_wdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the command list did not complete", cycle_count);
      $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other + 1);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Strobe lasts one cycle, then the pipeline delay
  task automatic cfg_write(input logic [1:0] offset, input logic [31:0] data);
    i_cfg_wr    = 1'b1;
    i_cfg_addr  = rr_pkg::cfg_reg_e'(offset);
    i_cfg_wdata = data;
    @(negedge clk);
    i_cfg_wr = 1'b0;
    repeat (MODE_STAGES) @(negedge clk);
  endtask

  // Valid held with stable payload until the DUT takes it
  task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
    logic taken;
    expected_q.push_back({addr, data});
    i_host_wvalid = 1'b1;
    i_host_waddr  = addr;
    i_host_wdata  = data;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = o_host_wready;
      @(negedge clk);
    end
    i_host_wvalid = 1'b0;
  endtask

  // Host offers a write that replay mode must refuse
  task automatic offer_blocked_write(input int cycles, input logic [15:0] addr,
                                     input logic [31:0] data);
    i_host_wvalid = 1'b1;
    i_host_waddr  = addr;
    i_host_wdata  = data;
    repeat (cycles) begin
      @(posedge clk);
      if (o_host_wready) begin
        err_other++;
        $display("Host write accepted during replay at t=%0t", $time);
      end
      @(negedge clk);
    end
    i_host_wvalid = 1'b0;
  endtask

  task automatic wait_idle();
    while (expected_q.size() != 0 || o_replay_busy) begin
      @(negedge clk);
    end
  endtask

  // Log strobe and append each take one cycle
  task automatic check_status(input int exp_count, input logic exp_overflow);
    wait_idle();
    repeat (2) @(negedge clk);
    if (o_trace_count !== CNT_W'(exp_count)) begin
      err_value++;
      $display("ERR t=%0t o_trace_count expected %0d got %0d", $time, exp_count, o_trace_count);
    end
    if (o_trace_overflow !== exp_overflow) begin
      err_value++;
      $display("ERR t=%0t o_trace_overflow expected %b got %b", $time, exp_overflow,
               o_trace_overflow);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [63:0] word;
    $readmemh("sim/rr_golden.txt", golden);
    while (cmd_count < GOLDEN_MAX && golden[cmd_count][63:60] != OP_END) begin
      cmd_count++;
    end
    if (cmd_count == 0) begin
      err_other++;
      $display("Golden file holds no commands");
    end
    // End marker counts as a line too
    cycle_limit = 64 * (cmd_count + 1);

    repeat (5) @(negedge clk);
    i_reset = 1'b0;
    if (o_cl_wvalid !== 1'b0) begin
      err_value++;
      $display("ERR t=%0t o_cl_wvalid expected 0 got %b", $time, o_cl_wvalid);
    end
    if (o_replay_busy !== 1'b0) begin
      err_value++;
      $display("ERR t=%0t o_replay_busy expected 0 got %b", $time, o_replay_busy);
    end
    check_status(0, 1'b0);

    for (int idx = 0; idx < cmd_count; idx++) begin
      word = golden[idx];
      case (word[63:60])
        OP_CFG:     cfg_write(word[33:32], word[31:0]);
        OP_HOST:    host_write(word[47:32], word[31:0]);
        OP_EXPECT:  expected_q.push_back(word[47:0]);
        OP_WAIT:    wait_idle();
        OP_STATUS:  check_status(int'(word[47:32]), word[0]);
        OP_BLOCKED: offer_blocked_write(int'(word[59:48]), word[47:32], word[31:0]);
        default: begin
          err_other++;
          $display("Unknown golden command %h at entry %0d", word, idx);
        end
      endcase
    end
    wait_idle();

    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/rr_golden.txt */
// One 64-bit hex word per line: op(1) arg(3) addr(4) data(8)
// op 1 cfg write (addr is offset), 2 host write, 3 expected replay write, 4 wait idle,
// 5 status (addr is count, data is overflow), 6 host write refused for arg cycles, 0 end
// Pass mode
2000001011110001
2000001411110002
5000000000000000
// Record three writes
1000000000000001
20000100aaaa0001
20000104aaaa0002
20000108aaaa0003
5000000300000000
// Replay them while the host is held off
1000000000000002
30000100aaaa0001
30000104aaaa0002
30000108aaaa0003
1000000200000000
600c0200deadbeef
4000000000000000
5000000300000000
// Clear, then overflow a depth of four
1000000100000000
5000000000000000
1000000000000001
20000300bbbb0001
20000304bbbb0002
20000308bbbb0003
2000030cbbbb0004
20000310bbbb0005
5000000400000001
// Only the first four come back
1000000000000002
30000300bbbb0001
30000304bbbb0002
30000308bbbb0003
3000030cbbbb0004
1000000200000000
4000000000000000
1000000100000000
5000000000000000
// Back to pass mode
1000000000000000
2000004011110003
5000000000000000
0000000000000000

/* rr_wrapper.f */
source/rr_pkg.sv
source/rr_csrs.sv
source/rr_write_recorder.sv
source/rr_trace_buffer.sv
source/rr_write_replayer.sv
source/rr_wrapper.sv
sim/tb_rr_wrapper.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rr_wrapper -f rr_wrapper.f -o tb_rr_wrapper &&
  ./obj_dir/tb_rr_wrapper | tee /dev/stderr | grep -qx "Result: PASSED" &&
  echo "Simulation run passed" ||
  { echo "Simulation run failed or did not build"; exit 1; }
